//--- source/lab4_pkg.sv
`default_nettype none

package lab4_pkg;

	////////////////////
	// array geometry

	localparam int NUM_LABS = 4;
	// broadcast needs a spare code, so a power of two gets one more bit
	localparam int LAB_SEL_W = (NUM_LABS == (1 << $clog2(NUM_LABS))) ?
		$clog2(NUM_LABS) + 1 : $clog2(NUM_LABS);
	localparam logic [LAB_SEL_W-1:0] LAB_SEL_ALL = '1;
	localparam int LAB_REG_W = 24;
	localparam int LAB_BIT_CNT_W = $clog2(LAB_REG_W);
	localparam logic [LAB_BIT_CNT_W-1:0] LAB_LAST_BIT = LAB_BIT_CNT_W'(LAB_REG_W - 1);

	// apb side
	localparam int APB_ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef logic [LAB_SEL_W-1:0] lab_sel_t;
	typedef logic [LAB_REG_W-1:0] lab_word_t;
	typedef logic [15:0] ramp_count_t;
	typedef logic [7:0] prescale_t;

	////////////////////
	// register map, byte offsets

	localparam logic [APB_ADDR_W-1:0] ADDR_CONTROL = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_SHIFT_PRESCALE = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_RAMP_DELAY = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] ADDR_WCLK_COUNT = 8'h10;
	localparam logic [APB_ADDR_W-1:0] ADDR_RAMP_CMD = 8'h14;
	localparam logic [APB_ADDR_W-1:0] ADDR_USER_WRITE = 8'h18;

	localparam prescale_t SHIFT_PRESCALE_DEFAULT = 8'd1;
	localparam ramp_count_t RAMP_DELAY_DEFAULT = 16'd0;
	localparam ramp_count_t WCLK_COUNT_DEFAULT = 16'd1024;

	// control register fields
	localparam int CTRL_RUNMODE_BIT = 1;
	localparam int CTRL_RAMP_BUSY_BIT = 3;
	localparam int CTRL_WILK_RESET_BIT = 8;
	localparam int CTRL_TEST_PATTERN_BIT = 15;
	localparam int CTRL_REGCLR_BIT = 16;

	// user write register fields
	localparam int UW_REQUEST_BIT = 31;
	localparam int UW_BUSY_BIT = 30;
	localparam int UW_SELECT_LSB = 24;

endpackage

`default_nettype wire

//--- source/lab4_if.sv
`timescale 1ns/1ps
`default_nettype none

// register strobes between the apb front end and the register bank
interface reg_access_if;
	logic wr;
	logic rd;
	logic [lab4_pkg::APB_ADDR_W-1:0] addr;
	logic [lab4_pkg::DATA_W-1:0] wdata;
	logic [lab4_pkg::DATA_W-1:0] rdata;
	logic err;

	modport master (output wr, rd, addr, wdata, input rdata, err);
	modport slave (input wr, rd, addr, wdata, output rdata, err);
endinterface

// one serial word for the chip loader, valid/ready handshake
interface serial_cmd_if;
	logic valid;
	logic ready;
	lab4_pkg::lab_sel_t sel;
	lab4_pkg::lab_word_t data;

	modport source (output valid, sel, data, input ready);
	modport sink (input valid, sel, data, output ready);
endinterface

// ramp sequencer control
interface ramp_cmd_if;
	logic start;
	logic abort;
	lab4_pkg::ramp_count_t delay;
	lab4_pkg::ramp_count_t count;
	logic busy;

	modport source (output start, abort, delay, count, input busy);
	modport sink (input start, abort, delay, count, output busy);
endinterface

`default_nettype wire

//--- source/lab4_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_apb_port (
	input wire clk_i,
	input wire reset_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [lab4_pkg::APB_ADDR_W-1:0] paddr_i,
	input wire [lab4_pkg::DATA_W-1:0] pwdata_i,
	output logic [lab4_pkg::DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	reg_access_if.master bus
);

	logic access;
	logic in_access_q;
	logic strobe;

	// access phase is psel together with penable
	assign access = psel_i & penable_i;

	// only the first cycle of an access phase issues a strobe
	assign strobe = access & ~in_access_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			in_access_q <= 1'b0;
		end else begin
			in_access_q <= access;
		end
	end

	////////////////////
	// towards the register bank

	assign bus.wr = strobe & pwrite_i;
	assign bus.rd = strobe & ~pwrite_i;
	assign bus.addr = paddr_i;
	assign bus.wdata = pwdata_i;

	////////////////////
	// back to the bus

	// zero wait states
	assign pready_o = psel_i;
	assign prdata_o = bus.rdata;
	// err is already qualified by the strobe
	assign pslverr_o = bus.err;

endmodule

`default_nettype wire

//--- source/lab4_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_regs (
	input wire clk_i,
	input wire reset_i,
	reg_access_if.slave bus,
	serial_cmd_if.source ser,
	ramp_cmd_if.source ramp,
	output lab4_pkg::prescale_t shift_prescale_o,
	output logic runmode_o,
	output logic regclr_o,
	output logic test_pattern_o
);

	logic [lab4_pkg::APB_ADDR_W-1:0] word_addr;
	logic hit_control;
	logic hit_prescale;
	logic hit_delay;
	logic hit_count;
	logic hit_ramp_cmd;
	logic hit_user_write;
	logic mapped;
	logic uw_accept;
	logic runmode_q;
	logic regclr_q;
	logic test_pattern_q;
	lab4_pkg::prescale_t shift_prescale_q;
	lab4_pkg::ramp_count_t ramp_delay_q;
	lab4_pkg::ramp_count_t wclk_count_q;
	logic uw_request_q;
	lab4_pkg::lab_sel_t uw_sel_q;
	lab4_pkg::lab_word_t uw_data_q;

	////////////////////
	// address decode

	// byte lanes are not decoded
	assign word_addr = {bus.addr[lab4_pkg::APB_ADDR_W-1:2], 2'b00};

	assign hit_control = (word_addr == lab4_pkg::ADDR_CONTROL);
	assign hit_prescale = (word_addr == lab4_pkg::ADDR_SHIFT_PRESCALE);
	assign hit_delay = (word_addr == lab4_pkg::ADDR_RAMP_DELAY);
	assign hit_count = (word_addr == lab4_pkg::ADDR_WCLK_COUNT);
	assign hit_ramp_cmd = (word_addr == lab4_pkg::ADDR_RAMP_CMD);
	assign hit_user_write = (word_addr == lab4_pkg::ADDR_USER_WRITE);
	assign mapped = hit_control | hit_prescale | hit_delay | hit_count |
		hit_ramp_cmd | hit_user_write;

	// a new user word is only taken once the last one went to the writer
	assign uw_accept = bus.wr & hit_user_write & ~uw_request_q;

	assign bus.err = ((bus.wr | bus.rd) & ~mapped) |
		(bus.wr & hit_user_write & uw_request_q);

	////////////////////
	// control and timing registers

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			runmode_q <= 1'b0;
			regclr_q <= 1'b0;
			test_pattern_q <= 1'b0;
			shift_prescale_q <= lab4_pkg::SHIFT_PRESCALE_DEFAULT;
			ramp_delay_q <= lab4_pkg::RAMP_DELAY_DEFAULT;
			wclk_count_q <= lab4_pkg::WCLK_COUNT_DEFAULT;
		end else if (bus.wr) begin
			if (hit_control) begin
				runmode_q <= bus.wdata[lab4_pkg::CTRL_RUNMODE_BIT];
				regclr_q <= bus.wdata[lab4_pkg::CTRL_REGCLR_BIT];
				test_pattern_q <= bus.wdata[lab4_pkg::CTRL_TEST_PATTERN_BIT];
			end
			if (hit_prescale) begin
				shift_prescale_q <= bus.wdata[7:0];
			end
			if (hit_delay) begin
				ramp_delay_q <= bus.wdata[15:0];
			end
			if (hit_count) begin
				wclk_count_q <= bus.wdata[15:0];
			end
		end
	end

	// user write word and its request flag
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			uw_request_q <= 1'b0;
			uw_sel_q <= '0;
			uw_data_q <= '0;
		end else begin
			if (uw_accept) begin
				uw_sel_q <= bus.wdata[lab4_pkg::UW_SELECT_LSB +: lab4_pkg::LAB_SEL_W];
				uw_data_q <= bus.wdata[lab4_pkg::LAB_REG_W-1:0];
			end
			// clears on the handshake
			if (uw_request_q && ser.ready) begin
				uw_request_q <= 1'b0;
			end else if (uw_accept) begin
				uw_request_q <= bus.wdata[lab4_pkg::UW_REQUEST_BIT];
			end
		end
	end

	////////////////////
	// commands to the engines

	assign ser.valid = uw_request_q;
	assign ser.sel = uw_sel_q;
	assign ser.data = uw_data_q;

	assign ramp.start = bus.wr & hit_ramp_cmd & bus.wdata[0];
	assign ramp.abort = bus.wr & hit_control & bus.wdata[lab4_pkg::CTRL_WILK_RESET_BIT];
	assign ramp.delay = ramp_delay_q;
	assign ramp.count = wclk_count_q;

	// readback
	always_comb begin
		bus.rdata = '0;
		case (word_addr)
			lab4_pkg::ADDR_CONTROL: begin
				bus.rdata[lab4_pkg::CTRL_RUNMODE_BIT] = runmode_q;
				bus.rdata[lab4_pkg::CTRL_RAMP_BUSY_BIT] = ramp.busy;
				bus.rdata[lab4_pkg::CTRL_TEST_PATTERN_BIT] = test_pattern_q;
				bus.rdata[lab4_pkg::CTRL_REGCLR_BIT] = regclr_q;
			end
			lab4_pkg::ADDR_SHIFT_PRESCALE: bus.rdata[7:0] = shift_prescale_q;
			lab4_pkg::ADDR_RAMP_DELAY: bus.rdata[15:0] = ramp_delay_q;
			lab4_pkg::ADDR_WCLK_COUNT: bus.rdata[15:0] = wclk_count_q;
			lab4_pkg::ADDR_RAMP_CMD: bus.rdata[0] = ramp.busy;
			lab4_pkg::ADDR_USER_WRITE: begin
				bus.rdata[lab4_pkg::UW_REQUEST_BIT] = uw_request_q;
				bus.rdata[lab4_pkg::UW_BUSY_BIT] = ~ser.ready;
				bus.rdata[lab4_pkg::UW_SELECT_LSB +: lab4_pkg::LAB_SEL_W] = uw_sel_q;
				bus.rdata[lab4_pkg::LAB_REG_W-1:0] = uw_data_q;
			end
			default: bus.rdata = '0;
		endcase
	end

	assign shift_prescale_o = shift_prescale_q;
	assign runmode_o = runmode_q;
	assign regclr_o = regclr_q;
	assign test_pattern_o = test_pattern_q;

endmodule

`default_nettype wire

//--- source/lab4_serial_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_serial_writer (
	input wire clk_i,
	input wire reset_i,
	input wire lab4_pkg::prescale_t prescale_i,
	serial_cmd_if.sink cmd,
	output logic [lab4_pkg::NUM_LABS-1:0] sin_o,
	output logic sclk_o,
	output logic [lab4_pkg::NUM_LABS-1:0] pclk_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_LATCH} phase_t;

	phase_t state_q;
	lab4_pkg::prescale_t prescale_q;
	lab4_pkg::prescale_t pre_cnt_q;
	logic [lab4_pkg::LAB_BIT_CNT_W-1:0] bit_cnt_q;
	lab4_pkg::lab_word_t shift_q;
	logic [lab4_pkg::NUM_LABS-1:0] mask_d;
	logic [lab4_pkg::NUM_LABS-1:0] mask_q;
	logic sclk_q;
	logic take;
	logic pre_done;

	assign cmd.ready = (state_q == ST_IDLE);
	assign take = cmd.valid & cmd.ready;
	assign pre_done = (pre_cnt_q == '0);

	// select to chip mask, out of range selects nothing
	always_comb begin
		mask_d = '0;
		if (cmd.sel == lab4_pkg::LAB_SEL_ALL) begin
			mask_d = '1;
		end else begin
			for (int i = 0; i < lab4_pkg::NUM_LABS; i++) begin
				if (cmd.sel == lab4_pkg::lab_sel_t'(i)) begin
					mask_d[i] = 1'b1;
				end
			end
		end
	end

	////////////////////
	// phase machine

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			sclk_q <= 1'b0;
			pre_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (take) begin
						state_q <= ST_SHIFT;
						pre_cnt_q <= prescale_i;
						bit_cnt_q <= '0;
					end
				end
				ST_SHIFT: begin
					if (pre_done) begin
						pre_cnt_q <= prescale_q;
						sclk_q <= ~sclk_q;
						// end of the high half closes the bit
						if (sclk_q) begin
							if (bit_cnt_q == lab4_pkg::LAB_LAST_BIT) begin
								state_q <= ST_LATCH;
							end else begin
								bit_cnt_q <= bit_cnt_q + 1'b1;
							end
						end
					end else begin
						pre_cnt_q <= pre_cnt_q - 1'b1;
					end
				end
				ST_LATCH: begin
					if (pre_done) begin
						state_q <= ST_IDLE;
					end else begin
						pre_cnt_q <= pre_cnt_q - 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// word, mask and prescale held for the whole sequence
	always_ff @(posedge clk_i) begin
		if (take) begin
			shift_q <= cmd.data;
			mask_q <= mask_d;
			prescale_q <= prescale_i;
		end else if (state_q == ST_SHIFT && pre_done && sclk_q) begin
			shift_q <= shift_q << 1;
		end
	end

	// msb first
	assign sin_o = mask_q & {lab4_pkg::NUM_LABS{(state_q == ST_SHIFT) &
		shift_q[lab4_pkg::LAB_REG_W-1]}};
	assign sclk_o = sclk_q;
	assign pclk_o = mask_q & {lab4_pkg::NUM_LABS{state_q == ST_LATCH}};

endmodule

`default_nettype wire

//--- source/lab4_wilkinson_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_wilkinson_ramp (
	input wire clk_i,
	input wire reset_i,
	ramp_cmd_if.sink cmd,
	output logic ramp_o,
	output logic wclk_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_DELAY, ST_WCLK} phase_t;

	phase_t state_q;
	lab4_pkg::ramp_count_t cnt_q;
	lab4_pkg::ramp_count_t count_q;
	logic wclk_q;

	////////////////////
	// sequencer

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			cnt_q <= '0;
			wclk_q <= 1'b0;
		end else if (cmd.abort) begin
			state_q <= ST_IDLE;
			wclk_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// a zero delay goes straight to the clock phase
					if (cmd.start) begin
						if (cmd.delay != '0) begin
							state_q <= ST_DELAY;
							cnt_q <= cmd.delay - 1'b1;
						end else if (cmd.count != '0) begin
							state_q <= ST_WCLK;
							cnt_q <= cmd.count - 1'b1;
						end
					end
				end
				ST_DELAY: begin
					if (cnt_q == '0) begin
						if (count_q != '0) begin
							state_q <= ST_WCLK;
							cnt_q <= count_q - 1'b1;
						end else begin
							state_q <= ST_IDLE;
						end
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				ST_WCLK: begin
					wclk_q <= ~wclk_q;
					if (cnt_q == '0) begin
						state_q <= ST_IDLE;
						wclk_q <= 1'b0;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// clock count captured at start
	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && cmd.start) begin
			count_q <= cmd.count;
		end
	end

	assign ramp_o = (state_q != ST_IDLE);
	assign cmd.busy = (state_q != ST_IDLE);
	assign wclk_o = wclk_q;

endmodule

`default_nettype wire

//--- source/lab4_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_ctrl_top (
	input wire clk_i,
	input wire reset_i,
	// apb slave
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [lab4_pkg::APB_ADDR_W-1:0] paddr_i,
	input wire [lab4_pkg::DATA_W-1:0] pwdata_i,
	output wire [lab4_pkg::DATA_W-1:0] prdata_o,
	output wire pready_o,
	output wire pslverr_o,
	// chip pins
	output wire [lab4_pkg::NUM_LABS-1:0] sin_o,
	output wire sclk_o,
	output wire [lab4_pkg::NUM_LABS-1:0] pclk_o,
	output wire ramp_o,
	output wire wclk_o,
	output wire runmode_o,
	output wire regclr_o,
	output wire test_pattern_o
);

	wire lab4_pkg::prescale_t shift_prescale;

	reg_access_if u_reg_bus ();
	serial_cmd_if u_ser_cmd ();
	ramp_cmd_if u_ramp_cmd ();

	////////////////////
	// bus front end and registers

	lab4_apb_port u_apb_port (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.bus(u_reg_bus.master)
	);

	lab4_regs u_regs (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bus(u_reg_bus.slave),
		.ser(u_ser_cmd.source),
		.ramp(u_ramp_cmd.source),
		.shift_prescale_o(shift_prescale),
		.runmode_o(runmode_o),
		.regclr_o(regclr_o),
		.test_pattern_o(test_pattern_o)
	);

	////////////////////
	// chip engines

	lab4_serial_writer u_serial_writer (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.prescale_i(shift_prescale),
		.cmd(u_ser_cmd.sink),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o)
	);

	lab4_wilkinson_ramp u_wilkinson_ramp (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.cmd(u_ramp_cmd.sink),
		.ramp_o(ramp_o),
		.wclk_o(wclk_o)
	);

endmodule

`default_nettype wire

//--- test/lab4_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module lab4_ctrl_props (
	input wire clk_i,
	input wire reset_i,
	input wire psel_i,
	input wire pready_i,
	input wire sclk_i,
	input wire [lab4_pkg::NUM_LABS-1:0] pclk_i,
	input wire ramp_i,
	input wire wclk_i
);

	int fail_count = 0;

	////////////////////
	// apb side

	// zero wait state slave
	ready_with_select: assert property (@(posedge clk_i) disable iff (reset_i)
		psel_i |-> pready_i)
	else begin
		$error("pready low while psel is high");
		fail_count++;
	end

	////////////////////
	// chip pins

	// latch pulse only after the last shift clock
	latch_apart_from_shift: assert property (@(posedge clk_i) disable iff (reset_i)
		!(sclk_i && (pclk_i != '0)))
	else begin
		$error("pclk and sclk high together");
		fail_count++;
	end

	wclk_inside_ramp: assert property (@(posedge clk_i) disable iff (reset_i)
		!ramp_i |-> !wclk_i)
	else begin
		$error("wclk high while ramp is low");
		fail_count++;
	end

	// one chip or broadcast
	latch_mask_shape: assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot0(pclk_i) || (pclk_i == '1))
	else begin
		$error("pclk drives a partial set of chips");
		fail_count++;
	end

endmodule

bind lab4_ctrl_top lab4_ctrl_props u_props (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.psel_i(psel_i),
	.pready_i(pready_o),
	.sclk_i(sclk_o),
	.pclk_i(pclk_o),
	.ramp_i(ramp_o),
	.wclk_i(wclk_o)
);

`default_nettype wire

//--- test/tb_lab4_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lab4_ctrl;

	localparam int CLK_HALF = 4;
	localparam int RESET_CYCLES = 16;
	localparam int WORD_BITS = 24;
	localparam int SEED = 39;
	localparam int POLL_LIMIT = 300;
	// worst case cycles per test
	// a serial word is 2*24+1 prescaled phases
	localparam int REG_TEST_CYCLES = 40 * 2;
	localparam int WORD_P1_CYCLES = (2 * WORD_BITS + 1) * 2 + 10;
	localparam int WORD_P3_CYCLES = (2 * WORD_BITS + 1) * 4 + 10;
	localparam int RAMP_TEST_CYCLES = 5 + 20 + 1000 + 20;
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + REG_TEST_CYCLES +
		3 * WORD_P1_CYCLES + WORD_P3_CYCLES + RAMP_TEST_CYCLES) + 200;

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;
	wire [lab4_pkg::NUM_LABS-1:0] sin;
	wire sclk;
	wire [lab4_pkg::NUM_LABS-1:0] pclk;
	wire ramp;
	wire wclk;
	wire runmode;
	wire regclr;
	wire test_pattern;

	int checks = 0;
	int errors = 0;
	logic [31:0] rng_state = SEED;

	// monitor state
	int sclk_rises = 0;
	int sclk_high_len = 0;
	int pclk_len = 0;
	int stray = 0;
	int exp_half = 2;
	logic [lab4_pkg::NUM_LABS-1:0] exp_mask = '0;
	lab4_pkg::lab_word_t rx_word [lab4_pkg::NUM_LABS];
	logic [31:0] delivered [$];
	logic sclk_prev = 1'b0;
	logic [lab4_pkg::NUM_LABS-1:0] pclk_prev = '0;
	logic wclk_prev = 1'b0;
	int ramp_len = 0;
	int wclk_rises = 0;
	int first_wclk = 0;

	lab4_ctrl_top u_lab4_ctrl_top (
		.clk_i(clk),
		.reset_i(reset),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.sin_o(sin),
		.sclk_o(sclk),
		.pclk_o(pclk),
		.ramp_o(ramp),
		.wclk_o(wclk),
		.runmode_o(runmode),
		.regclr_o(regclr),
		.test_pattern_o(test_pattern)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] user_word(input lab4_pkg::lab_sel_t sel,
		input lab4_pkg::lab_word_t word);
		logic [31:0] w;
		w = '0;
		w[lab4_pkg::UW_REQUEST_BIT] = 1'b1;
		w[lab4_pkg::UW_SELECT_LSB +: lab4_pkg::LAB_SEL_W] = sel;
		w[lab4_pkg::LAB_REG_W-1:0] = word;
		return w;
	endfunction

	// chip index in the top byte and the word below
	function automatic logic [31:0] delivery_entry(input int chip,
		input lab4_pkg::lab_word_t word);
		return {8'(chip), word};
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	////////////////////
	// apb transfers start just after a rising edge

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_reg(input string name, input logic [7:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic err;
		read_reg(addr, data, err);
		expect_equal(name, exp, data);
		expect_equal({name, " pslverr"}, 0, 32'(err));
	endtask

	task automatic wait_writer_idle(input string name);
		logic [31:0] data;
		logic err;
		int polls;
		polls = 0;
		data = '1;
		while ((data[lab4_pkg::UW_REQUEST_BIT] || data[lab4_pkg::UW_BUSY_BIT]) &&
			polls < POLL_LIMIT) begin
			read_reg(lab4_pkg::ADDR_USER_WRITE, data, err);
			polls++;
		end
		if (data[lab4_pkg::UW_REQUEST_BIT] || data[lab4_pkg::UW_BUSY_BIT]) begin
			$display("%s: the serial writer did not return to idle in time", name);
			errors++;
		end
	endtask

	task automatic wait_ramp_idle(input string name);
		logic [31:0] data;
		logic err;
		int polls;
		polls = 0;
		data = '1;
		while (data[lab4_pkg::CTRL_RAMP_BUSY_BIT] && polls < POLL_LIMIT) begin
			read_reg(lab4_pkg::ADDR_CONTROL, data, err);
			polls++;
		end
		if (data[lab4_pkg::CTRL_RAMP_BUSY_BIT]) begin
			$display("%s: the ramp sequencer stayed busy too long", name);
			errors++;
		end
	endtask

	task automatic clear_monitors(input logic [lab4_pkg::NUM_LABS-1:0] mask, input int half);
		sclk_rises = 0;
		stray = 0;
		exp_mask = mask;
		exp_half = half;
		delivered.delete();
		ramp_len = 0;
		wclk_rises = 0;
		first_wclk = 0;
	endtask

	// one entry per selected chip, lowest chip first
	task automatic check_delivery(input string name, input logic [lab4_pkg::NUM_LABS-1:0] mask,
		input lab4_pkg::lab_word_t word);
		logic [31:0] got;
		for (int i = 0; i < lab4_pkg::NUM_LABS; i++) begin
			if (mask[i]) begin
				got = '1;
				if (delivered.size() > 0) begin
					got = delivered.pop_front();
				end
				expect_equal({name, " word"}, delivery_entry(i, word), got);
			end
		end
	endtask

	task automatic run_serial_case(input string name, input lab4_pkg::lab_sel_t sel,
		input logic [7:0] prescale);
		lab4_pkg::lab_word_t word;
		logic [lab4_pkg::NUM_LABS-1:0] mask;
		logic err;
		rng_state = xorshift(rng_state);
		word = rng_state[23:0];
		mask = '0;
		if (sel == lab4_pkg::LAB_SEL_ALL) begin
			mask = '1;
		end else begin
			mask[sel] = 1'b1;
		end
		write_reg(lab4_pkg::ADDR_SHIFT_PRESCALE, {24'd0, prescale}, err);
		clear_monitors(mask, int'(prescale) + 1);
		write_reg(lab4_pkg::ADDR_USER_WRITE, user_word(sel, word), err);
		expect_equal({name, " accepted"}, 0, 32'(err));
		wait_writer_idle(name);
		expect_equal({name, " sclk rises"}, WORD_BITS, sclk_rises);
		expect_equal({name, " latch pulses"}, $countones(mask), delivered.size());
		check_delivery(name, mask, word);
		expect_equal({name, " stray chip outputs"}, 0, stray);
	endtask

	////////////////////
	// pin monitors sample mid cycle

	always @(negedge clk) begin
		if (!reset) begin
			if (sclk && !sclk_prev) begin
				sclk_rises++;
				for (int i = 0; i < lab4_pkg::NUM_LABS; i++) begin
					rx_word[i] = {rx_word[i][WORD_BITS-2:0], sin[i]};
				end
			end
			if (sclk) begin
				sclk_high_len++;
			end else if (sclk_prev) begin
				expect_equal("sclk high phase", exp_half, sclk_high_len);
				sclk_high_len = 0;
			end
			for (int i = 0; i < lab4_pkg::NUM_LABS; i++) begin
				if (pclk[i] && !pclk_prev[i]) begin
					delivered.push_back(delivery_entry(i, rx_word[i]));
				end
			end
			if (pclk != '0) begin
				pclk_len++;
			end else if (pclk_prev != '0) begin
				expect_equal("pclk high phase", exp_half, pclk_len);
				pclk_len = 0;
			end
			if (((sin | pclk) & ~exp_mask) != '0) begin
				stray++;
			end
			// ramp cycle of the first wclk high
			if (ramp) begin
				ramp_len++;
				if (wclk && !wclk_prev && first_wclk == 0) begin
					first_wclk = ramp_len;
				end
			end
			if (wclk && !wclk_prev) begin
				wclk_rises++;
			end
		end
		sclk_prev = sclk;
		pclk_prev = pclk;
		wclk_prev = wclk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [31:0] data;
		logic err;
		lab4_pkg::lab_word_t first_word;
		lab4_pkg::lab_word_t second_word;
		int prop_fails;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// defaults after reset
		expect_reg("reset control", lab4_pkg::ADDR_CONTROL, 32'd0);
		expect_reg("reset prescale", lab4_pkg::ADDR_SHIFT_PRESCALE, 32'd1);
		expect_reg("reset ramp delay", lab4_pkg::ADDR_RAMP_DELAY, 32'd0);
		expect_reg("reset wclk count", lab4_pkg::ADDR_WCLK_COUNT, 32'd1024);
		expect_reg("reset ramp command", lab4_pkg::ADDR_RAMP_CMD, 32'd0);
		expect_reg("reset user write", lab4_pkg::ADDR_USER_WRITE, 32'd0);
		expect_equal("reset chip pins", 0, 32'({sin, pclk, sclk, ramp, wclk}));
		expect_equal("reset control pins", 0, 32'({runmode, regclr, test_pattern}));

		// register access
		data = (32'd1 << lab4_pkg::CTRL_RUNMODE_BIT) |
			(32'd1 << lab4_pkg::CTRL_TEST_PATTERN_BIT) | (32'd1 << lab4_pkg::CTRL_REGCLR_BIT);
		write_reg(lab4_pkg::ADDR_CONTROL, data, err);
		expect_reg("control readback", lab4_pkg::ADDR_CONTROL, data);
		expect_equal("control pins set", 32'h7, 32'({runmode, regclr, test_pattern}));
		// one bit at a time so that each pin is tied to its own field
		write_reg(lab4_pkg::ADDR_CONTROL, 32'd1 << lab4_pkg::CTRL_RUNMODE_BIT, err);
		expect_equal("control pins runmode only", 32'h4,
			32'({runmode, regclr, test_pattern}));
		write_reg(lab4_pkg::ADDR_CONTROL, 32'd1 << lab4_pkg::CTRL_TEST_PATTERN_BIT, err);
		expect_equal("control pins test pattern only", 32'h1,
			32'({runmode, regclr, test_pattern}));
		write_reg(lab4_pkg::ADDR_CONTROL, 32'd0, err);
		expect_equal("control pins clear", 0, 32'({runmode, regclr, test_pattern}));
		write_reg(lab4_pkg::ADDR_SHIFT_PRESCALE, 32'h0000_00A5, err);
		expect_reg("prescale readback", lab4_pkg::ADDR_SHIFT_PRESCALE, 32'hA5);
		expect_reg("prescale byte alias", 8'h07, 32'hA5);
		write_reg(lab4_pkg::ADDR_RAMP_DELAY, 32'h1234, err);
		expect_reg("ramp delay readback", lab4_pkg::ADDR_RAMP_DELAY, 32'h1234);
		write_reg(lab4_pkg::ADDR_WCLK_COUNT, 32'hBEEF, err);
		expect_reg("wclk count readback", lab4_pkg::ADDR_WCLK_COUNT, 32'hBEEF);
		read_reg(8'h08, data, err);
		expect_equal("unmapped read error", 1, 32'(err));
		write_reg(8'h40, 32'h5555_5555, err);
		expect_equal("unmapped write error", 1, 32'(err));

		// serial words
		run_serial_case("single chip write", 3'd1, 8'd1);
		run_serial_case("broadcast write", lab4_pkg::LAB_SEL_ALL, 8'd3);

		// back pressure on a busy writer
		write_reg(lab4_pkg::ADDR_SHIFT_PRESCALE, 32'd1, err);
		clear_monitors(4'b0100, 2);
		rng_state = xorshift(rng_state);
		first_word = rng_state[23:0];
		rng_state = xorshift(rng_state);
		second_word = rng_state[23:0];
		write_reg(lab4_pkg::ADDR_USER_WRITE, user_word(3'd2, first_word), err);
		write_reg(lab4_pkg::ADDR_USER_WRITE, user_word(3'd2, second_word), err);
		expect_equal("pending write accepted", 0, 32'(err));
		read_reg(lab4_pkg::ADDR_USER_WRITE, data, err);
		expect_equal("pending request bit", 1, 32'(data[lab4_pkg::UW_REQUEST_BIT]));
		write_reg(lab4_pkg::ADDR_USER_WRITE, user_word(3'd0, 24'h0), err);
		expect_equal("write refused while pending", 1, 32'(err));
		wait_writer_idle("back pressure");
		expect_equal("back pressure sclk rises", 2 * WORD_BITS, sclk_rises);
		expect_equal("back pressure latch pulses", 2, delivered.size());
		check_delivery("back pressure first", 4'b0100, first_word);
		check_delivery("back pressure second", 4'b0100, second_word);
		read_reg(lab4_pkg::ADDR_USER_WRITE, data, err);
		expect_equal("request bit cleared", 0, 32'(data[lab4_pkg::UW_REQUEST_BIT]));

		// ramp with delay 5 and count 20
		write_reg(lab4_pkg::ADDR_RAMP_DELAY, 32'd5, err);
		write_reg(lab4_pkg::ADDR_WCLK_COUNT, 32'd20, err);
		clear_monitors('0, 2);
		write_reg(lab4_pkg::ADDR_RAMP_CMD, 32'd1, err);
		wait_ramp_idle("ramp run");
		expect_equal("ramp high cycles", 25, ramp_len);
		expect_equal("wclk rising edges", 10, wclk_rises);
		// wclk starts low right after the delay
		expect_equal("first wclk high cycle", 7, first_wclk);

		// wilkinson reset stops a long ramp
		write_reg(lab4_pkg::ADDR_RAMP_DELAY, 32'd0, err);
		write_reg(lab4_pkg::ADDR_WCLK_COUNT, 32'd1000, err);
		write_reg(lab4_pkg::ADDR_RAMP_CMD, 32'd1, err);
		read_reg(lab4_pkg::ADDR_CONTROL, data, err);
		expect_equal("ramp busy before abort", 1, 32'(data[lab4_pkg::CTRL_RAMP_BUSY_BIT]));
		write_reg(lab4_pkg::ADDR_CONTROL, 32'd1 << lab4_pkg::CTRL_WILK_RESET_BIT, err);
		expect_equal("ramp pins after abort", 0, 32'({ramp, wclk}));
		read_reg(lab4_pkg::ADDR_CONTROL, data, err);
		expect_equal("ramp busy after abort", 0, 32'(data[lab4_pkg::CTRL_RAMP_BUSY_BIT]));

		prop_fails = u_lab4_ctrl_top.u_props.fail_count;
		$display("checks %0d, check errors %0d, assertion failures %0d",
			checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
source/lab4_pkg.sv
source/lab4_if.sv
source/lab4_apb_port.sv
source/lab4_regs.sv
source/lab4_serial_writer.sv
source/lab4_wilkinson_ramp.sv
source/lab4_ctrl_top.sv
test/lab4_ctrl_properties.sv
test/tb_lab4_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the lab4 controller testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_lab4_ctrl -f list.f -o tb_lab4_ctrl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_lab4_ctrl +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
